/* design/bch_params.svh */
`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

// Field width in bits, GF(2^5)
`define BCH_M 5

// Correction capability in errors
`define BCH_T 3

// Syndromes needed by the solver, two per correctable error
`define BCH_NSYN 6

// Code length and multiplicative group order
`define BCH_N 31

// Low terms of x^5 + x^2 + 1
// The x^5 term is folded back through these bits
`define BCH_PRIM 5'b00101

`endif

/* design/bchPkg.sv */
`include "bch_params.svh"

package bchPkg;

    // One element of GF(2^5)
    typedef logic [`BCH_M-1:0] gfElem_t;

    // S1 sits in element 0
    typedef gfElem_t [`BCH_NSYN-1:0] synVec_t;

    // Coefficient 0 first, degree up to T
    typedef gfElem_t [`BCH_T:0] locPoly_t;

    // Wide enough for a degree above T and for the iteration index
    typedef logic [3:0] degree_t;

    typedef enum logic [1:0] {
        phIdle,
        phCalcD,
        phUpdate,
        phFinish
    } iterPhase_t;

    // Polynomial equal to 1
    parameter locPoly_t polyOne = locPoly_t'(1);

    // Powers of alpha
    function automatic gfElem_t gfExp(input gfElem_t e);
        case (e)
            5'd0:  return 5'b00001;
            5'd1:  return 5'b00010;
            5'd2:  return 5'b00100;
            5'd3:  return 5'b01000;
            5'd4:  return 5'b10000;
            5'd5:  return 5'b00101;
            5'd6:  return 5'b01010;
            5'd7:  return 5'b10100;
            5'd8:  return 5'b01101;
            5'd9:  return 5'b11010;
            5'd10: return 5'b10001;
            5'd11: return 5'b00111;
            5'd12: return 5'b01110;
            5'd13: return 5'b11100;
            5'd14: return 5'b11101;
            5'd15: return 5'b11111;
            5'd16: return 5'b11011;
            5'd17: return 5'b10011;
            5'd18: return 5'b00011;
            5'd19: return 5'b00110;
            5'd20: return 5'b01100;
            5'd21: return 5'b11000;
            5'd22: return 5'b10101;
            5'd23: return 5'b01111;
            5'd24: return 5'b11110;
            5'd25: return 5'b11001;
            5'd26: return 5'b10111;
            5'd27: return 5'b01011;
            5'd28: return 5'b10110;
            5'd29: return 5'b01001;
            5'd30: return 5'b10010;
            default: return 5'b00000;
        endcase
    endfunction

    // Log by walking alpha^k through the field
    // Zero is never matched and keeps the flag value 31
    function automatic gfElem_t gfLog(input gfElem_t a);
        gfElem_t x;
        gfElem_t res;
        x = gfElem_t'(1);
        res = gfElem_t'(`BCH_N);
        for (int k = 0; k < `BCH_N; k++) begin
            if (x == a) begin
                res = gfElem_t'(k);
            end
            // Multiply by alpha, reduce on carry out
            x = {x[`BCH_M-2:0], 1'b0} ^ (x[`BCH_M-1] ? `BCH_PRIM : '0);
        end
        return res;
    endfunction

    function automatic gfElem_t gfMul(input gfElem_t a, input gfElem_t b);
        logic [`BCH_M:0] logSum;
        if (a == '0 || b == '0) begin
            return '0;
        end
        // One extra bit keeps the carry of the log sum
        logSum = gfLog(a) + gfLog(b);
        return gfExp(gfElem_t'(logSum % `BCH_N));
    endfunction

    function automatic gfElem_t gfInv(input gfElem_t a);
        if (a == '0) begin
            return '0;
        end
        return gfExp(gfElem_t'((`BCH_N - gfLog(a)) % `BCH_N));
    endfunction

endpackage

/* design/syndromeCapture.sv */
module syndromeCapture
    import bchPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  synVec_t syndromes,
    input  logic    finish,
    output synVec_t synHeld,
    output logic    go
);

    logic busy;
    logic accept;

    // Idle, or the running solve ends on this edge
    assign accept = start && (!busy || finish);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            go   <= 1'b0;
        end else begin
            go <= accept;
            // New request wins over the clear from finish
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    // Syndromes stay frozen for the whole solve
    always_ff @(posedge clk) begin
        if (accept) begin
            synHeld <= syndromes;
        end
    end

    // A finish only ends a solve that this side launched
    finishOnlyBusy: assert property (
        @(posedge clk) disable iff (reset)
        finish |-> busy
    );

endmodule

/* design/discrepancyCalc.sv */
`include "bch_params.svh"

module discrepancyCalc
    import bchPkg::*;
(
    input  synVec_t  synHeld,
    input  locPoly_t sigma,
    input  degree_t  iter,
    input  degree_t  degree,
    output gfElem_t  discrepancy
);

    always_comb begin
        // Start from the syndrome of this step
        if (iter < degree_t'(`BCH_NSYN)) begin
            discrepancy = synHeld[iter];
        end else begin
            discrepancy = '0;
        end
        // Sum sigma_i * S_(n-i) for i up to the current degree
        // Only coefficients that exist in sigma are used
        for (int i = 1; i <= `BCH_T; i++) begin
            if (i <= degree && i <= iter && iter < degree_t'(`BCH_NSYN)) begin
                discrepancy = discrepancy ^ gfMul(sigma[i], synHeld[iter - i]);
            end
        end
    end

endmodule

/* design/bmEngine.sv */
`include "bch_params.svh"

module bmEngine
    import bchPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     go,
    input  synVec_t  synHeld,
    output locPoly_t sigmaOut,
    output degree_t  degreeOut,
    output logic     finish
);

    iterPhase_t phase;
    // Iteration index, LFSR length and gap since the last length change
    degree_t    n;
    degree_t    lfsrLen;
    degree_t    gap;

    locPoly_t   sigma;
    locPoly_t   helperB;
    gfElem_t    d;
    gfElem_t    dNow;
    gfElem_t    dInv;

    locPoly_t   sigmaNext;
    locPoly_t   helperNext;
    degree_t    lenNext;
    degree_t    gapNext;

    discrepancyCalc u_discrepancyCalc (
        .synHeld     (synHeld),
        .sigma       (sigma),
        .iter        (n),
        .degree      (lfsrLen),
        .discrepancy (dNow)
    );

    assign dInv = gfInv(d);

    // One Berlekamp-Massey step from the registered discrepancy
    always_comb begin
        sigmaNext  = sigma;
        helperNext = helperB;
        lenNext    = lfsrLen;
        gapNext    = gap + degree_t'(1);
        if (d != '0) begin
            // sigma ^= d * x^gap * B, terms above x^3 fall off
            for (int j = 0; j <= `BCH_T; j++) begin
                if (j >= gap) begin
                    sigmaNext[j] = sigma[j] ^ gfMul(d, helperB[j - gap]);
                end
            end
            // Length change, B takes the old sigma over d
            if ((2 * lfsrLen) <= n) begin
                lenNext = degree_t'(n + degree_t'(1) - lfsrLen);
                gapNext = degree_t'(1);
                for (int j = 0; j <= `BCH_T; j++) begin
                    helperNext[j] = gfMul(sigma[j], dInv);
                end
            end
        end
    end

    // Phase and counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase   <= phIdle;
            n       <= '0;
            lfsrLen <= '0;
            gap     <= degree_t'(1);
        end else begin
            case (phase)
                phIdle: begin
                    if (go) begin
                        n       <= '0;
                        lfsrLen <= '0;
                        gap     <= degree_t'(1);
                        phase   <= phCalcD;
                    end
                end
                phCalcD: begin
                    phase <= phUpdate;
                end
                phUpdate: begin
                    lfsrLen <= lenNext;
                    gap     <= gapNext;
                    // Last step uses S6
                    if (n == degree_t'(`BCH_NSYN - 1)) begin
                        phase <= phFinish;
                    end else begin
                        n     <= n + degree_t'(1);
                        phase <= phCalcD;
                    end
                end
                phFinish: begin
                    phase <= phIdle;
                end
            endcase
        end
    end

    // Polynomials and discrepancy
    always_ff @(posedge clk) begin
        if (phase == phIdle && go) begin
            sigma   <= polyOne;
            helperB <= polyOne;
        end else if (phase == phCalcD) begin
            d <= dNow;
        end else if (phase == phUpdate) begin
            sigma   <= sigmaNext;
            helperB <= helperNext;
        end
    end

    assign finish    = (phase == phFinish);
    assign sigmaOut  = sigma;
    assign degreeOut = lfsrLen;

    // Capture side must never launch a solve mid-run
    goOnlyIdle: assert property (
        @(posedge clk) disable iff (reset)
        go |-> phase == phIdle
    );

endmodule

/* design/locatorOutput.sv */
`include "bch_params.svh"

module locatorOutput
    import bchPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     finish,
    input  locPoly_t sigmaIn,
    input  degree_t  degreeIn,
    output locPoly_t sigma,
    output degree_t  degree,
    output logic     failure,
    output logic     done
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sigma   <= polyOne;
            degree  <= '0;
            failure <= 1'b0;
            done    <= 1'b0;
        end else begin
            // One done per result load
            done <= finish;
            if (finish) begin
                sigma  <= sigmaIn;
                degree <= degreeIn;
                // More than T errors, locator cannot be trusted
                failure <= (degreeIn > degree_t'(`BCH_T));
            end
        end
    end

    // finish is a single-cycle phase, so done is too
    donePulse: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    );

endmodule

/* design/bmDecoder.sv */
module bmDecoder
    import bchPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  synVec_t  syndromes,
    output locPoly_t sigma,
    output degree_t  degree,
    output logic     failure,
    output logic     done
);

    synVec_t  synHeld;
    logic     go;
    logic     finish;
    locPoly_t sigmaEng;
    degree_t  degreeEng;

    // Input side, owns the busy flag
    syndromeCapture u_syndromeCapture (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .syndromes (syndromes),
        .finish    (finish),
        .synHeld   (synHeld),
        .go        (go)
    );

    // Six two-cycle iterations
    bmEngine u_bmEngine (
        .clk       (clk),
        .reset     (reset),
        .go        (go),
        .synHeld   (synHeld),
        .sigmaOut  (sigmaEng),
        .degreeOut (degreeEng),
        .finish    (finish)
    );

    locatorOutput u_locatorOutput (
        .clk      (clk),
        .reset    (reset),
        .finish   (finish),
        .sigmaIn  (sigmaEng),
        .degreeIn (degreeEng),
        .sigma    (sigma),
        .degree   (degree),
        .failure  (failure),
        .done     (done)
    );

endmodule

/* tests/bmChecker.sv */
`include "bch_params.svh"

module bmChecker
    import bchPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  synVec_t           syndromes,
    input  logic              rootsKnown,
    input  logic [`BCH_N-1:0] rootMask,
    input  int                rootCount,
    input  locPoly_t          sigma,
    input  degree_t           degree,
    input  logic              failure,
    input  logic              done,
    output int                errorCount,
    output int                checkCount,
    output int                pending
);

    // done is seen high on the 15th edge after the start edge
    localparam int doneEdge = 15;
    // Starts on the next 13 edges hit a busy solver
    localparam int busyEdges = 14;

    int       edgeNo;
    int       freeAt;
    int       errs = 0;
    int       checks = 0;
    logic     resetChecked;
    locPoly_t expSigma;
    int       expLen;

    // One entry per accepted start, oldest first
    int                dueQ[$];
    locPoly_t          sigmaQ[$];
    int                lenQ[$];
    logic              knownQ[$];
    logic [`BCH_N-1:0] maskQ[$];
    int                countQ[$];

    // Reference Berlekamp-Massey, locator kept to T+1 coefficients
    task automatic solveModel(input synVec_t s, output locPoly_t sig, output int len);
        locPoly_t c;
        locPoly_t b;
        locPoly_t prev;
        gfElem_t  d;
        int       l;
        int       m;
        c = polyOne;
        b = polyOne;
        l = 0;
        m = 1;
        for (int n = 0; n < `BCH_NSYN; n++) begin
            d = s[n];
            for (int i = 1; i <= `BCH_T; i++) begin
                if (i <= l && i <= n) begin
                    d = d ^ gfMul(c[i], s[n - i]);
                end
            end
            if (d == '0) begin
                m = m + 1;
            end else begin
                prev = c;
                // C(x) -= d * x^m * B(x)
                for (int j = m; j <= `BCH_T; j++) begin
                    c[j] = c[j] ^ gfMul(d, b[j - m]);
                end
                if (2 * l <= n) begin
                    l = n + 1 - l;
                    for (int j = 0; j <= `BCH_T; j++) begin
                        b[j] = gfMul(prev[j], gfInv(d));
                    end
                    m = 1;
                end else begin
                    m = m + 1;
                end
            end
        end
        sig = c;
        len = l;
    endtask

    // sigma evaluated at alpha^-p, zero at a true error location
    function automatic gfElem_t evalAtInverse(input locPoly_t sig, input int p);
        gfElem_t acc;
        int      e;
        acc = '0;
        for (int i = 0; i <= `BCH_T; i++) begin
            e = (`BCH_N - ((i * p) % `BCH_N)) % `BCH_N;
            acc = acc ^ gfMul(sig[i], gfExp(gfElem_t'(e)));
        end
        return acc;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        checks = checks + 1;
        if (expVal !== actVal) begin
            $display("mismatch time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expVal, actVal);
            errs = errs + 1;
        end
    endtask

    // Compare DUT results against the oldest pending solve
    task automatic checkResult();
        compareValue("sigma", sigmaQ[0], sigma);
        compareValue("degree", lenQ[0], degree);
        compareValue("failure", lenQ[0] > `BCH_T, failure);
        if (knownQ[0]) begin
            compareValue("degree(error count)", countQ[0], degree);
            for (int p = 0; p < `BCH_N; p++) begin
                if (maskQ[0][p]) begin
                    compareValue($sformatf("sigma(alpha^-%0d)", p), 0,
                                 evalAtInverse(sigma, p));
                    // Single error, sigma1 is the locator itself
                    if (countQ[0] == 1) begin
                        compareValue("sigma1", gfExp(gfElem_t'(p)), sigma[1]);
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            edgeNo = 0;
            freeAt = 0;
            resetChecked = 1'b0;
        end else begin
            edgeNo = edgeNo + 1;
            // Output state straight out of reset
            if (!resetChecked) begin
                compareValue("done", 0, done);
                compareValue("failure", 0, failure);
                compareValue("sigma", polyOne, sigma);
                compareValue("degree", 0, degree);
                resetChecked = 1'b1;
            end
            // Done handled before a new start on the same edge
            if (dueQ.size() > 0 && dueQ[0] == edgeNo) begin
                if (done) begin
                    checkResult();
                end else begin
                    $display("done did not pulse 14 cycles after the start, time %0t", $time);
                    errs = errs + 1;
                end
                void'(dueQ.pop_front());
                void'(sigmaQ.pop_front());
                void'(lenQ.pop_front());
                void'(knownQ.pop_front());
                void'(maskQ.pop_front());
                void'(countQ.pop_front());
            end else if (done) begin
                $display("done pulsed with no solve pending, time %0t", $time);
                errs = errs + 1;
            end
            // Busy starts are dropped by the DUT
            if (start && edgeNo >= freeAt) begin
                solveModel(syndromes, expSigma, expLen);
                dueQ.push_back(edgeNo + doneEdge);
                sigmaQ.push_back(expSigma);
                lenQ.push_back(expLen);
                knownQ.push_back(rootsKnown);
                maskQ.push_back(rootMask);
                countQ.push_back(rootCount);
                freeAt = edgeNo + busyEdges;
            end
        end
        errorCount <= errs;
        checkCount <= checks;
        pending    <= dueQ.size();
    end

endmodule

/* tests/tbBmDecoder.sv */
`include "bch_params.svh"

module tbBmDecoder
    import bchPkg::*;
();

    localparam int runsPerTest = 40;
    // 40 runs x 6 tests x 20 cycles, plus margin
    localparam int timeoutCycles = runsPerTest * 6 * 20 + 100;

    logic              clk;
    logic              reset;
    logic              start;
    synVec_t           syndromes;
    locPoly_t          sigma;
    degree_t           degree;
    logic              failure;
    logic              done;
    logic              rootsKnown;
    logic [`BCH_N-1:0] rootMask;
    int                rootCount;
    int                errorCount;
    int                checkCount;
    int                pending;
    logic [31:0]       rngState;
    int                cycleCount = 0;
    int                testNo = 0;
    int                errAtStart;
    string             testName;

    bmDecoder u_bmDecoder (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .syndromes (syndromes),
        .sigma     (sigma),
        .degree    (degree),
        .failure   (failure),
        .done      (done)
    );

    bmChecker u_bmChecker (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .syndromes  (syndromes),
        .rootsKnown (rootsKnown),
        .rootMask   (rootMask),
        .rootCount  (rootCount),
        .sigma      (sigma),
        .degree     (degree),
        .failure    (failure),
        .done       (done),
        .errorCount (errorCount),
        .checkCount (checkCount),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Hard stop for a hung solve
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeoutCycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextRand(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    // S_j is the sum of alpha^(j*p) over the error positions
    function automatic synVec_t syndromesFor(input logic [`BCH_N-1:0] mask);
        synVec_t s;
        s = '0;
        for (int j = 1; j <= `BCH_NSYN; j++) begin
            for (int p = 0; p < `BCH_N; p++) begin
                if (mask[p]) begin
                    s[j-1] = s[j-1] ^ gfExp(gfElem_t'((j * p) % `BCH_N));
                end
            end
        end
        return s;
    endfunction

    // Distinct positions 0 to 30
    task automatic pickErrors(input int count, output logic [`BCH_N-1:0] mask);
        logic [31:0] r;
        mask = '0;
        while ($countones(mask) < count) begin
            nextRand(r);
            mask[r % `BCH_N] = 1'b1;
        end
    endtask

    task automatic randomSyndromes(output synVec_t s);
        logic [31:0] r;
        nextRand(r);
        s = synVec_t'(r[29:0]);
    endtask

    // One-cycle start, returns on the edge that samples it
    task automatic issueStart(input synVec_t s, input logic known,
                              input logic [`BCH_N-1:0] mask, input int count);
        @(posedge clk);
        start      <= 1'b1;
        syndromes  <= s;
        rootsKnown <= known;
        rootMask   <= mask;
        rootCount  <= count;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Checker queue drains when every accepted solve is done
    task automatic waitIdle();
        @(posedge clk);
        while (pending != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic runSolve(input synVec_t s, input logic known,
                            input logic [`BCH_N-1:0] mask, input int count);
        issueStart(s, known, mask, count);
        waitIdle();
    endtask

    task automatic startTest(input string name);
        testNo = testNo + 1;
        testName = name;
        errAtStart = errorCount;
    endtask

    task automatic finishTest();
        repeat (2) @(posedge clk);
        $display("test %0d %s finished with %0d errors", testNo, testName,
                 errorCount - errAtStart);
    endtask

    initial begin
        logic [31:0]       r;
        logic [`BCH_N-1:0] mask;
        logic [`BCH_N-1:0] maskB;
        synVec_t           syn;
        int                cnt;
        rngState = 32'h1cfd;
        reset      <= 1'b1;
        start      <= 1'b0;
        syndromes  <= '0;
        rootsKnown <= 1'b0;
        rootMask   <= '0;
        rootCount  <= 0;

        // Reset state is checked on the first edge after release
        startTest("reset and zero errors");
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        runSolve('0, 1'b1, '0, 0);
        finishTest();

        startTest("single errors");
        for (int k = 0; k < runsPerTest; k++) begin
            pickErrors(1, mask);
            runSolve(syndromesFor(mask), 1'b1, mask, 1);
        end
        finishTest();

        startTest("two and three errors");
        for (int k = 0; k < runsPerTest; k++) begin
            nextRand(r);
            cnt = 2 + int'(r[0]);
            pickErrors(cnt, mask);
            runSolve(syndromesFor(mask), 1'b1, mask, cnt);
        end
        finishTest();

        // Degree above T shows up here
        startTest("arbitrary syndromes");
        for (int k = 0; k < runsPerTest; k++) begin
            randomSyndromes(syn);
            runSolve(syn, 1'b0, '0, 0);
        end
        finishTest();

        // Second start sampled 5 cycles after the accepted one
        startTest("start while busy");
        for (int k = 0; k < 4; k++) begin
            pickErrors(2, mask);
            randomSyndromes(syn);
            issueStart(syndromesFor(mask), 1'b1, mask, 2);
            repeat (3) @(posedge clk);
            issueStart(syn, 1'b0, '0, 0);
            waitIdle();
            // Room for a stray second done
            repeat (20) @(posedge clk);
        end
        finishTest();

        // Second start sampled on the finish edge, then on the done edge
        startTest("latency and back-to-back");
        for (int k = 0; k < 4; k++) begin
            pickErrors(3, mask);
            pickErrors(1, maskB);
            issueStart(syndromesFor(mask), 1'b1, mask, 3);
            repeat (12 + (k % 2)) @(posedge clk);
            issueStart(syndromesFor(maskB), 1'b1, maskB, 1);
            waitIdle();
        end
        finishTest();

        $display("%0d tests, %0d checks, %0d errors", testNo, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/bchPkg.sv
design/syndromeCapture.sv
design/discrepancyCalc.sv
design/bmEngine.sv
design/locatorOutput.sv
design/bmDecoder.sv
tests/bmChecker.sv
tests/tbBmDecoder.sv

/* Makefile */
# Verilator build and run for the BCH Berlekamp-Massey solver
VERILATOR ?= verilator
TOP       ?= tbBmDecoder
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
